// ==== compile.f ====
+incdir+sim
common/board_pkg.sv
source/rtc_tick_gen.sv
fan_ctrl/fan_pwm.sv
regbus/board_reg_resp.sv
source/board_ctrl_top.sv
sim/board_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f compile.f \
  --top-module board_ctrl_tb \
  -o board_ctrl_sim

# Exit status of the simulation is the result
./obj_dir/board_ctrl_sim

// ==== sim/board_ctrl_tests.svh ====
//////////////////////////////
// Host bus access
//////////////////////////////

// Four-phase handshake with ack on the third falling edge
task automatic bus_access(input logic write, input board_pkg::reg_addr_t a,
                          input board_pkg::reg_data_t wd,
                          output board_pkg::reg_data_t rd, output logic e);
  int latency;
  @(negedge soc_clk);
  req     = 1'b1;
  we      = write;
  addr    = a;
  wdata   = wd;
  latency = 0;
  while (!ack) begin
    @(negedge soc_clk);
    latency++;
  end
  expect_equal("ack_latency", 3, latency);
  rd = rdata;
  e  = err;
  if (write) begin
    expect_equal("write_rdata", 0, rd);
  end
  req = 1'b0;
  @(negedge soc_clk);
  while (ack) begin
    @(negedge soc_clk);
  end
endtask

task automatic bus_write(input board_pkg::reg_addr_t a, input board_pkg::reg_data_t wd,
                         output logic e);
  board_pkg::reg_data_t unused_rd;
  bus_access(1'b1, a, wd, unused_rd, e);
endtask

task automatic bus_read(input board_pkg::reg_addr_t a, output board_pkg::reg_data_t rd,
                        output logic e);
  bus_access(1'b0, a, '0, rd, e);
endtask

// Settle for 17 cycles, then count high cycles over one frame
task automatic count_fan_pulses(output int highs);
  repeat (17) @(negedge soc_clk);
  highs = 0;
  repeat (16) begin
    @(negedge soc_clk);
    if (fan_pwm) begin
      highs++;
    end
  end
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic after_reset();
  board_pkg::reg_data_t rd;
  logic                 e;
  expect_equal("reset_ack", 0, 32'(ack));
  expect_equal("reset_err", 0, 32'(err));
  expect_equal("reset_pwm", 0, 32'(fan_pwm));
  bus_read(board_pkg::AddrId, rd, e);
  expect_equal("id_read", board_pkg::BoardIdCode, rd);
  expect_equal("id_read_err", 0, 32'(e));
endtask

task automatic scratch_round_trip();
  board_pkg::reg_data_t wd;
  board_pkg::reg_data_t rd;
  logic                 e;
  int                   i;
  for (i = 0; i < 10; i++) begin
    wd = rand_bits(32);
    bus_write(board_pkg::AddrScratch, wd, e);
    expect_equal("scratch_write_err", 0, 32'(e));
    bus_read(board_pkg::AddrScratch, rd, e);
    expect_equal("scratch_read", wd, rd);
  end
  // Id is read only and not flagged
  bus_write(board_pkg::AddrId, rand_bits(32), e);
  expect_equal("id_write_err", 0, 32'(e));
  bus_read(board_pkg::AddrId, rd, e);
  expect_equal("id_after_write", board_pkg::BoardIdCode, rd);
endtask

task automatic unmapped_access();
  board_pkg::reg_data_t keep;
  board_pkg::reg_data_t rd;
  logic                 e;
  int                   i;
  for (i = 5; i < 16; i++) begin
    bus_read(i[3:0], rd, e);
    expect_equal("unmapped_read", board_pkg::ErrVal, rd);
    expect_equal("unmapped_read_err", 1, 32'(e));
  end
  keep = rand_bits(32);
  bus_write(board_pkg::AddrScratch, keep, e);
  for (i = 5; i < 16; i++) begin
    bus_write(i[3:0], rand_bits(32), e);
    expect_equal("unmapped_write_err", 1, 32'(e));
  end
  bus_read(board_pkg::AddrScratch, rd, e);
  expect_equal("scratch_kept", keep, rd);
  expect_equal("scratch_kept_err", 0, 32'(e));
endtask

task automatic rtc_counting();
  board_pkg::reg_data_t c0;
  board_pkg::reg_data_t c1;
  logic                 e;
  int                   t0;
  int                   t1;
  int                   expected;
  int                   delta;
  int                   ticks;
  bus_read(board_pkg::AddrRtc, c0, e);
  t0 = cycle_cnt;
  repeat (100) @(negedge soc_clk);
  bus_read(board_pkg::AddrRtc, c1, e);
  t1       = cycle_cnt;
  expected = (t1 - t0) / TickDiv;
  delta    = c1 - c0;
  // Divider phase against the reads allows one tick either way
  if (delta >= expected - 1 && delta <= expected + 1) begin
    delta = expected;
  end
  expect_equal("rtc_delta", expected, delta);
  ticks = 0;
  repeat (50) begin
    @(negedge soc_clk);
    if (rtc_tick) begin
      ticks++;
    end
  end
  expect_equal("rtc_ticks", 50 / TickDiv, ticks);
endtask

task automatic fan_duty_select();
  logic [31:0]          rnd;
  board_pkg::fan_duty_t sw_duty;
  board_pkg::fan_duty_t ovr_duty;
  board_pkg::reg_data_t rd;
  logic                 e;
  int                   highs;
  rnd      = rand_bits(4);
  sw_duty  = rnd[3:0];
  rnd      = rand_bits(4);
  ovr_duty = rnd[3:0];
  // Zero duty would look the same as the reset state
  if (sw_duty == 4'h0) begin
    sw_duty = 4'h1;
  end
  if (ovr_duty == sw_duty) begin
    ovr_duty = sw_duty ^ 4'h8;
  end
  @(negedge soc_clk);
  fan_sw = sw_duty;
  count_fan_pulses(highs);
  expect_equal("fan_switch_duty", 32'(sw_duty), highs);
  bus_write(board_pkg::AddrFan, {27'd0, 1'b1, ovr_duty}, e);
  count_fan_pulses(highs);
  expect_equal("fan_override_duty", 32'(ovr_duty), highs);
  bus_read(board_pkg::AddrFan, rd, e);
  expect_equal("fan_readback", {27'd0, 1'b1, ovr_duty}, rd);
  bus_write(board_pkg::AddrFan, 32'd0, e);
  count_fan_pulses(highs);
  expect_equal("fan_switch_restored", 32'(sw_duty), highs);
endtask

task automatic boot_mode_override();
  logic [31:0]           rnd;
  board_pkg::boot_mode_t forced;
  board_pkg::reg_data_t  rd;
  logic                  e;
  int                    i;
  for (i = 0; i < 4; i++) begin
    @(negedge soc_clk);
    boot_mode_in = i[1:0];
    @(negedge soc_clk);
    expect_equal("boot_follow", i, 32'(boot_mode_out));
  end
  rnd          = rand_bits(2);
  forced       = rnd[1:0];
  boot_mode_in = ~forced;
  bus_write(board_pkg::AddrBoot, {29'd0, 1'b1, forced}, e);
  expect_equal("boot_forced", 32'(forced), 32'(boot_mode_out));
  bus_read(board_pkg::AddrBoot, rd, e);
  expect_equal("boot_readback", {29'd0, 1'b1, forced}, rd);
endtask

// ==== sim/board_ctrl_tb.sv ====
`timescale 1ns/1ns

module board_ctrl_tb;

  // RTC divider used for this run
  localparam int TickDiv = 5;

  // Worst case run length: bus accesses plus fixed waits, with margin
  localparam int NumAccesses   = 54;
  localparam int AccessCycles  = 6;
  localparam int WaitCycles    = 270;
  localparam int TimeoutCycles = 6 * (NumAccesses * AccessCycles + WaitCycles + 4);

  logic                  soc_clk;
  logic                  rst_n;
  logic                  req;
  logic                  we;
  board_pkg::reg_addr_t  addr;
  board_pkg::reg_data_t  wdata;
  logic                  ack;
  logic                  err;
  board_pkg::reg_data_t  rdata;
  board_pkg::fan_duty_t  fan_sw;
  board_pkg::boot_mode_t boot_mode_in;
  logic                  rtc_tick;
  logic                  fan_pwm;
  board_pkg::boot_mode_t boot_mode_out;

  logic [15:0]           lfsr_q;
  int                    cycle_cnt;

  board_ctrl_top #(
    .RtcDiv      ( 16'(TickDiv) )
  ) board_ctrl_top_i (
    .soc_clk     ( soc_clk       ),
    .rst_n       ( rst_n         ),
    .req_i       ( req           ),
    .we_i        ( we            ),
    .addr_i      ( addr          ),
    .wdata_i     ( wdata         ),
    .ack_o       ( ack           ),
    .err_o       ( err           ),
    .rdata_o     ( rdata         ),
    .fan_sw_i    ( fan_sw        ),
    .boot_mode_i ( boot_mode_in  ),
    .rtc_tick_o  ( rtc_tick      ),
    .fan_pwm_o   ( fan_pwm       ),
    .boot_mode_o ( boot_mode_out )
  );

  //////////////////////////////
  // Clock and cycle counter
  //////////////////////////////

  initial begin
    soc_clk = 1'b0;
    forever #20 soc_clk = ~soc_clk;
  end

  always @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  //////////////////////////////
  // Random data and checking
  //////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  `include "board_ctrl_tests.svh"

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial begin
    repeat (TimeoutCycles) @(posedge soc_clk);
    $display("CHECKS FAILED");
    $fatal(1, "Run timed out after %0d cycles", TimeoutCycles);
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    rst_n        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    wdata        = '0;
    fan_sw       = '0;
    boot_mode_in = '0;
    lfsr_q       = 16'd57227;
    repeat (2) @(posedge soc_clk);
    @(negedge soc_clk);
    rst_n = 1'b1;
    @(negedge soc_clk);

    after_reset();
    scratch_round_trip();
    unmapped_access();
    rtc_counting();
    fan_duty_select();
    boot_mode_override();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== source/board_ctrl_top.sv ====
`timescale 1ns/1ns

module board_ctrl_top #(
  parameter logic [15:0] RtcDiv = 16'd25
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // Host register port
  input  logic                  req_i,
  input  logic                  we_i,
  input  board_pkg::reg_addr_t  addr_i,
  input  board_pkg::reg_data_t  wdata_i,
  output logic                  ack_o,
  output logic                  err_o,
  output board_pkg::reg_data_t  rdata_o,
  // Board pins
  input  board_pkg::fan_duty_t  fan_sw_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  output logic                  rtc_tick_o,
  output logic                  fan_pwm_o,
  output board_pkg::boot_mode_t boot_mode_o
);

  board_pkg::rtc_count_t rtc_count;
  logic                  fan_ovr_en;
  board_pkg::fan_duty_t  fan_ovr_duty;
  board_pkg::fan_duty_t  fan_duty;

  //////////////////////////////
  // RTC tick
  //////////////////////////////

  rtc_tick_gen #(
    .RtcDiv      ( RtcDiv     )
  ) i_rtc_tick_gen (
    .soc_clk     ( soc_clk    ),
    .rst_n       ( rst_n      ),
    .rtc_tick_o  ( rtc_tick_o ),
    .rtc_count_o ( rtc_count  )
  );

  //////////////////////////////
  // Fan control
  //////////////////////////////

  fan_pwm i_fan_pwm (
    .soc_clk    ( soc_clk      ),
    .rst_n      ( rst_n        ),
    .fan_sw_i   ( fan_sw_i     ),
    .ovr_en_i   ( fan_ovr_en   ),
    .ovr_duty_i ( fan_ovr_duty ),
    .duty_o     ( fan_duty     ),
    .fan_pwm_o  ( fan_pwm_o    )
  );

  //////////////////////////////
  // Register responder
  //////////////////////////////

  board_reg_resp i_board_reg_resp (
    .soc_clk        ( soc_clk      ),
    .rst_n          ( rst_n        ),
    .req_i          ( req_i        ),
    .we_i           ( we_i         ),
    .addr_i         ( addr_i       ),
    .wdata_i        ( wdata_i      ),
    .ack_o          ( ack_o        ),
    .err_o          ( err_o        ),
    .rdata_o        ( rdata_o      ),
    .rtc_count_i    ( rtc_count    ),
    .fan_duty_i     ( fan_duty     ),
    .boot_mode_i    ( boot_mode_i  ),
    .fan_ovr_en_o   ( fan_ovr_en   ),
    .fan_ovr_duty_o ( fan_ovr_duty ),
    .boot_mode_o    ( boot_mode_o  )
  );

endmodule

// ==== regbus/board_reg_resp.sv ====
`timescale 1ns/1ns

module board_reg_resp (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  // Host register port
  input  logic                  req_i,
  input  logic                  we_i,
  input  board_pkg::reg_addr_t  addr_i,
  input  board_pkg::reg_data_t  wdata_i,
  output logic                  ack_o,
  output logic                  err_o,
  output board_pkg::reg_data_t  rdata_o,
  // Board state
  input  board_pkg::rtc_count_t rtc_count_i,
  input  board_pkg::fan_duty_t  fan_duty_i,
  input  board_pkg::boot_mode_t boot_mode_i,
  // Overrides
  output logic                  fan_ovr_en_o,
  output board_pkg::fan_duty_t  fan_ovr_duty_o,
  output board_pkg::boot_mode_t boot_mode_o
);

  board_pkg::resp_state_e state_q;
  board_pkg::resp_state_e state_d;
  logic                   req_q;
  logic                   do_access;
  logic                   addr_hit;
  board_pkg::reg_data_t   read_data;
  board_pkg::reg_data_t   rdata_q;
  logic                   err_q;

  board_pkg::reg_data_t   scratch_q;
  logic                   fan_ovr_en_q;
  board_pkg::fan_duty_t   fan_ovr_duty_q;
  logic                   boot_sel_q;
  board_pkg::boot_mode_t  boot_val_q;

  //////////////////////////////
  // Handshake FSM
  //////////////////////////////

  // Request sampled once before the FSM sees it
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      board_pkg::RespIdle: begin
        if (req_q) begin
          state_d = board_pkg::RespAccess;
        end
      end
      board_pkg::RespAccess: begin
        state_d = board_pkg::RespAck;
      end
      board_pkg::RespAck: begin
        // Hold ack until the host lets go
        if (!req_i) begin
          state_d = board_pkg::RespIdle;
        end
      end
      default: begin
        state_d = board_pkg::RespIdle;
      end
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= board_pkg::RespIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Access completes on the edge that raises ack
  assign do_access = (state_q == board_pkg::RespAccess);

  //////////////////////////////
  // Decode and read mux
  //////////////////////////////

  always_comb begin
    addr_hit  = 1'b1;
    read_data = board_pkg::ErrVal;
    case (addr_i)
      board_pkg::AddrId:      read_data = board_pkg::BoardIdCode;
      board_pkg::AddrRtc:     read_data = rtc_count_i;
      board_pkg::AddrFan:     read_data = {27'd0, fan_ovr_en_q, fan_duty_i};
      board_pkg::AddrBoot:    read_data = {29'd0, boot_sel_q, boot_mode_o};
      board_pkg::AddrScratch: read_data = scratch_q;
      default:                addr_hit  = 1'b0;
    endcase
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (do_access) begin
      err_q <= ~addr_hit;
    end
  end

  // Writes return zero
  always_ff @(posedge soc_clk) begin
    if (do_access) begin
      rdata_q <= we_i ? '0 : read_data;
    end
  end

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  // Id and RTC are read only, unmapped writes are dropped
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      scratch_q      <= '0;
      fan_ovr_en_q   <= 1'b0;
      fan_ovr_duty_q <= '0;
      boot_sel_q     <= 1'b0;
      boot_val_q     <= '0;
    end else if (do_access && we_i) begin
      case (addr_i)
        board_pkg::AddrFan: begin
          fan_ovr_duty_q <= wdata_i[3:0];
          fan_ovr_en_q   <= wdata_i[4];
        end
        board_pkg::AddrBoot: begin
          boot_val_q <= wdata_i[1:0];
          boot_sel_q <= wdata_i[2];
        end
        board_pkg::AddrScratch: begin
          scratch_q <= wdata_i;
        end
        default: begin
        end
      endcase
    end
  end

  assign ack_o          = (state_q == board_pkg::RespAck);
  assign err_o          = err_q;
  assign rdata_o        = rdata_q;
  assign fan_ovr_en_o   = fan_ovr_en_q;
  assign fan_ovr_duty_o = fan_ovr_duty_q;

  // Effective boot mode
  assign boot_mode_o = boot_sel_q ? boot_val_q : boot_mode_i;

endmodule

// ==== fan_ctrl/fan_pwm.sv ====
`timescale 1ns/1ns

module fan_pwm (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  board_pkg::fan_duty_t fan_sw_i,
  input  logic                 ovr_en_i,
  input  board_pkg::fan_duty_t ovr_duty_i,
  output board_pkg::fan_duty_t duty_o,
  output logic                 fan_pwm_o
);

  logic [3:0]           slot_q;
  logic [3:0]           slot_d;
  logic                 frame_end;
  board_pkg::fan_duty_t duty_sel;
  board_pkg::fan_duty_t duty_q;
  board_pkg::fan_duty_t duty_d;
  logic                 pwm_q;

  //////////////////////////////
  // Duty source
  //////////////////////////////

  // Software override wins over the board switches
  assign duty_sel = ovr_en_i ? ovr_duty_i : fan_sw_i;

  //////////////////////////////
  // Frame and slot counter
  //////////////////////////////

  // 16 slots per frame, counter wraps by itself
  assign slot_d    = slot_q + 4'd1;
  assign frame_end = (slot_q == 4'hf);

  // Duty only changes at a frame boundary
  assign duty_d = frame_end ? duty_sel : duty_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_q <= '0;
      duty_q <= '0;
    end else begin
      slot_q <= slot_d;
      duty_q <= duty_d;
    end
  end

  //////////////////////////////
  // PWM output
  //////////////////////////////

  // Registered compare against the next slot keeps the pin glitch free,
  // high for the first duty slots of every frame
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= (slot_d < duty_d);
    end
  end

  assign fan_pwm_o = pwm_q;
  assign duty_o    = duty_q;

endmodule

// ==== source/rtc_tick_gen.sv ====
`timescale 1ns/1ns

module rtc_tick_gen #(
  parameter logic [15:0] RtcDiv = 16'd25
) (
  input  logic                  soc_clk,
  input  logic                  rst_n,
  output logic                  rtc_tick_o,
  output board_pkg::rtc_count_t rtc_count_o
);

  logic [15:0]           div_q;
  logic                  div_wrap;
  logic                  tick_q;
  board_pkg::rtc_count_t count_q;

  //////////////////////////////
  // Divider
  //////////////////////////////

  // Last soc_clk cycle of an RTC period
  assign div_wrap = (div_q == RtcDiv - 16'd1);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_q <= '0;
    end else if (div_wrap) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 16'd1;
    end
  end

  // One-cycle tick, registered off the wrap
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= div_wrap;
    end
  end

  //////////////////////////////
  // Tick counter
  //////////////////////////////

  // Advances on the edge after each tick
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (tick_q) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign rtc_tick_o  = tick_q;
  assign rtc_count_o = count_q;

endmodule

// ==== common/board_pkg.sv ====
package board_pkg;

  //////////////////////////////
  // Field types
  //////////////////////////////

  // Register port
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Fan duty in sixteenths
  typedef logic [3:0]  fan_duty_t;

  typedef logic [1:0]  boot_mode_t;
  typedef logic [31:0] rtc_count_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam reg_addr_t AddrId      = 4'd0;
  localparam reg_addr_t AddrRtc     = 4'd1;
  localparam reg_addr_t AddrFan     = 4'd2;
  localparam reg_addr_t AddrBoot    = 4'd3;
  localparam reg_addr_t AddrScratch = 4'd4;

  // Returned on reads of unmapped addresses
  localparam reg_data_t ErrVal      = 32'hBADC_AB1E;

  // Board identification word
  localparam reg_data_t BoardIdCode = 32'hB0A2_D001;

  // Register responder handshake states
  typedef enum logic [1:0] {
    RespIdle,
    RespAccess,
    RespAck
  } resp_state_e;

endpackage
